// File: Bender.yml
package:
  name: n310_mgmt

sources:
  # package first, then leaf modules, then the top level
  - rtl/n310_mgmt_pkg.sv
  - rtl/axil_addr_decoder.sv
  - rtl/misc_regs.sv
  - rtl/axil_dummy_slave.sv
  - rtl/heartbeat_led.sv
  - rtl/n310_mgmt.sv
  - target: test
    files:
      - verif/n310_mgmt_tb.sv

// File: n310_mgmt.f
rtl/n310_mgmt_pkg.sv
rtl/axil_addr_decoder.sv
rtl/misc_regs.sv
rtl/axil_dummy_slave.sv
rtl/heartbeat_led.sv
rtl/n310_mgmt.sv
verif/n310_mgmt_tb.sv

// File: rtl/axil_addr_decoder.sv
////////////////////
// register bus address decoder
// steers each access to the misc window or the error responder
////////////////////
`default_nettype none

module axil_addr_decoder (
  input  wire                                     FCLK_CLK0,
  input  wire                                     FCLK_RESET0,
  // master side
  input  wire  [n310_mgmt_pkg::BUS_AW-1:0]        axi_awaddr,
  input  wire                                     axi_awvalid,
  output logic                                    axi_awready,
  input  wire  [n310_mgmt_pkg::REG_DWIDTH-1:0]    axi_wdata,
  input  wire  [n310_mgmt_pkg::REG_SW-1:0]        axi_wstrb,
  input  wire                                     axi_wvalid,
  output logic                                    axi_wready,
  output logic [n310_mgmt_pkg::RESP_W-1:0]        axi_bresp,
  output logic                                    axi_bvalid,
  input  wire                                     axi_bready,
  input  wire  [n310_mgmt_pkg::BUS_AW-1:0]        axi_araddr,
  input  wire                                     axi_arvalid,
  output logic                                    axi_arready,
  output logic [n310_mgmt_pkg::REG_DWIDTH-1:0]    axi_rdata,
  output logic [n310_mgmt_pkg::RESP_W-1:0]        axi_rresp,
  output logic                                    axi_rvalid,
  input  wire                                     axi_rready,
  // misc window
  output logic [n310_mgmt_pkg::REG_AWIDTH-1:0]    misc_awaddr,
  output logic                                    misc_awvalid,
  input  wire                                     misc_awready,
  output logic [n310_mgmt_pkg::REG_DWIDTH-1:0]    misc_wdata,
  output logic [n310_mgmt_pkg::REG_SW-1:0]        misc_wstrb,
  output logic                                    misc_wvalid,
  input  wire                                     misc_wready,
  input  wire  [n310_mgmt_pkg::RESP_W-1:0]        misc_bresp,
  input  wire                                     misc_bvalid,
  output logic                                    misc_bready,
  output logic [n310_mgmt_pkg::REG_AWIDTH-1:0]    misc_araddr,
  output logic                                    misc_arvalid,
  input  wire                                     misc_arready,
  input  wire  [n310_mgmt_pkg::REG_DWIDTH-1:0]    misc_rdata,
  input  wire  [n310_mgmt_pkg::RESP_W-1:0]        misc_rresp,
  input  wire                                     misc_rvalid,
  output logic                                    misc_rready,
  // error responder, handshakes only
  output logic                                    dmy_awvalid,
  input  wire                                     dmy_awready,
  output logic                                    dmy_wvalid,
  input  wire                                     dmy_wready,
  input  wire  [n310_mgmt_pkg::RESP_W-1:0]        dmy_bresp,
  input  wire                                     dmy_bvalid,
  output logic                                    dmy_bready,
  output logic                                    dmy_arvalid,
  input  wire                                     dmy_arready,
  input  wire  [n310_mgmt_pkg::REG_DWIDTH-1:0]    dmy_rdata,
  input  wire  [n310_mgmt_pkg::RESP_W-1:0]        dmy_rresp,
  input  wire                                     dmy_rvalid,
  output logic                                    dmy_rready
);

  logic wr_hit, rd_hit;
  // one outstanding access per direction, plus who took it
  logic wr_pend, wr_misc;
  logic rd_pend, rd_misc;

  // window hit on the bits above the slave offset
  assign wr_hit = axi_awaddr[31:14] == n310_mgmt_pkg::REG_BASE_MISC[31:14];
  assign rd_hit = axi_araddr[31:14] == n310_mgmt_pkg::REG_BASE_MISC[31:14];

  ////////////////////
  // write path
  ////////////////////

  assign misc_awaddr  = axi_awaddr[n310_mgmt_pkg::REG_AWIDTH-1:0];
  assign misc_wdata   = axi_wdata;
  assign misc_wstrb   = axi_wstrb;
  // requests held back while a response is still owed
  assign misc_awvalid = axi_awvalid & ~wr_pend & wr_hit;
  assign misc_wvalid  = axi_wvalid & ~wr_pend & wr_hit;
  assign dmy_awvalid  = axi_awvalid & ~wr_pend & ~wr_hit;
  assign dmy_wvalid   = axi_wvalid & ~wr_pend & ~wr_hit;
  assign axi_awready  = ~wr_pend & (wr_hit ? misc_awready : dmy_awready);
  assign axi_wready   = ~wr_pend & (wr_hit ? misc_wready : dmy_wready);

  // response from the recorded target only
  assign axi_bvalid  = wr_pend & (wr_misc ? misc_bvalid : dmy_bvalid);
  assign axi_bresp   = wr_misc ? misc_bresp : dmy_bresp;
  assign misc_bready = axi_bready & wr_pend & wr_misc;
  assign dmy_bready  = axi_bready & wr_pend & ~wr_misc;

  always_ff @(posedge FCLK_CLK0) begin
    if (FCLK_RESET0) begin
      wr_pend <= 1'b0;
      wr_misc <= 1'b0;
    end else if (axi_awvalid && axi_wvalid && axi_awready && axi_wready) begin
      wr_pend <= 1'b1;
      wr_misc <= wr_hit;
    end else if (axi_bvalid && axi_bready) begin
      wr_pend <= 1'b0;
    end
  end

  ////////////////////
  // read path
  ////////////////////

  assign misc_araddr  = axi_araddr[n310_mgmt_pkg::REG_AWIDTH-1:0];
  assign misc_arvalid = axi_arvalid & ~rd_pend & rd_hit;
  assign dmy_arvalid  = axi_arvalid & ~rd_pend & ~rd_hit;
  assign axi_arready  = ~rd_pend & (rd_hit ? misc_arready : dmy_arready);

  assign axi_rvalid  = rd_pend & (rd_misc ? misc_rvalid : dmy_rvalid);
  assign axi_rdata   = rd_misc ? misc_rdata : dmy_rdata;
  assign axi_rresp   = rd_misc ? misc_rresp : dmy_rresp;
  assign misc_rready = axi_rready & rd_pend & rd_misc;
  assign dmy_rready  = axi_rready & rd_pend & ~rd_misc;

  always_ff @(posedge FCLK_CLK0) begin
    if (FCLK_RESET0) begin
      rd_pend <= 1'b0;
      rd_misc <= 1'b0;
    end else if (axi_arvalid && axi_arready) begin
      rd_pend <= 1'b1;
      rd_misc <= rd_hit;
    end else if (axi_rvalid && axi_rready) begin
      rd_pend <= 1'b0;
    end
  end

  // a slave only answers a request this decoder sent it
  assert property (@(posedge FCLK_CLK0) disable iff (FCLK_RESET0)
    (misc_bvalid || dmy_bvalid) |-> wr_pend && (misc_bvalid ? wr_misc : !wr_misc));
  assert property (@(posedge FCLK_CLK0) disable iff (FCLK_RESET0)
    (misc_rvalid || dmy_rvalid) |-> rd_pend && (misc_rvalid ? rd_misc : !rd_misc));

endmodule

`default_nettype wire

// File: rtl/axil_dummy_slave.sv
////////////////////
// fallback responder for unmapped addresses
////////////////////
`default_nettype none

module axil_dummy_slave #(
  parameter bit DEC_ERR = 1'b1
) (
  input  wire                                   FCLK_CLK0,
  input  wire                                   FCLK_RESET0,
  input  wire                                   dmy_awvalid,
  output logic                                  dmy_awready,
  input  wire                                   dmy_wvalid,
  output logic                                  dmy_wready,
  output logic [n310_mgmt_pkg::RESP_W-1:0]      dmy_bresp,
  output logic                                  dmy_bvalid,
  input  wire                                   dmy_bready,
  input  wire                                   dmy_arvalid,
  output logic                                  dmy_arready,
  output logic [n310_mgmt_pkg::REG_DWIDTH-1:0]  dmy_rdata,
  output logic [n310_mgmt_pkg::RESP_W-1:0]      dmy_rresp,
  output logic                                  dmy_rvalid,
  input  wire                                   dmy_rready
);

  // accept anything, one per direction
  assign dmy_awready = dmy_awvalid & dmy_wvalid & ~dmy_bvalid;
  assign dmy_wready  = dmy_awready;
  assign dmy_arready = dmy_arvalid & ~dmy_rvalid;

  // fixed answer, no data
  assign dmy_bresp = DEC_ERR ? n310_mgmt_pkg::RESP_DECERR : n310_mgmt_pkg::RESP_OKAY;
  assign dmy_rresp = dmy_bresp;
  assign dmy_rdata = '0;

  always_ff @(posedge FCLK_CLK0) begin
    if (FCLK_RESET0) begin
      dmy_bvalid <= 1'b0;
      dmy_rvalid <= 1'b0;
    end else begin
      // response one cycle after the handshake
      if (dmy_awready) begin
        dmy_bvalid <= 1'b1;
      end else if (dmy_bready) begin
        dmy_bvalid <= 1'b0;
      end
      if (dmy_arready) begin
        dmy_rvalid <= 1'b1;
      end else if (dmy_rready) begin
        dmy_rvalid <= 1'b0;
      end
    end
  end

  // write response held until the master takes it
  assert property (@(posedge FCLK_CLK0) disable iff (FCLK_RESET0)
    dmy_bvalid && !dmy_bready |=> dmy_bvalid);

endmodule

`default_nettype wire

// File: rtl/heartbeat_led.sv
////////////////////
// heartbeat blinker for the link panel LED
////////////////////
`default_nettype none

module heartbeat_led #(
  parameter int HB_BIT = n310_mgmt_pkg::HEARTBEAT_BIT
) (
  input  wire   FCLK_CLK0,
  input  wire   FCLK_RESET0,
  output logic  led
);

  // only bits up to the tap are needed
  logic [HB_BIT:0] count;

  always_ff @(posedge FCLK_CLK0) begin
    if (FCLK_RESET0) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  // toggles every 2^HB_BIT cycles
  assign led = count[HB_BIT];

endmodule

`default_nettype wire

// File: rtl/misc_regs.sv
////////////////////
// misc register window
// scratch, ID, SFP PHY status and GPS LED control
////////////////////
`default_nettype none

module misc_regs (
  input  wire                                     FCLK_CLK0,
  input  wire                                     FCLK_RESET0,
  input  wire  [n310_mgmt_pkg::REG_AWIDTH-1:0]    misc_awaddr,
  input  wire                                     misc_awvalid,
  output logic                                    misc_awready,
  input  wire  [n310_mgmt_pkg::REG_DWIDTH-1:0]    misc_wdata,
  input  wire  [n310_mgmt_pkg::REG_SW-1:0]        misc_wstrb,
  input  wire                                     misc_wvalid,
  output logic                                    misc_wready,
  output logic [n310_mgmt_pkg::RESP_W-1:0]        misc_bresp,
  output logic                                    misc_bvalid,
  input  wire                                     misc_bready,
  input  wire  [n310_mgmt_pkg::REG_AWIDTH-1:0]    misc_araddr,
  input  wire                                     misc_arvalid,
  output logic                                    misc_arready,
  output logic [n310_mgmt_pkg::REG_DWIDTH-1:0]    misc_rdata,
  output logic [n310_mgmt_pkg::RESP_W-1:0]        misc_rresp,
  output logic                                    misc_rvalid,
  input  wire                                     misc_rready,
  input  wire  [n310_mgmt_pkg::PHY_STATUS_W-1:0]  sfp0_phy_status,
  input  wire  [n310_mgmt_pkg::PHY_STATUS_W-1:0]  sfp1_phy_status,
  output logic                                    led_gps
);

  logic                                  wr_fire;
  logic                                  rd_fire;
  logic [n310_mgmt_pkg::REG_DWIDTH-1:0]  scratch;

  // address and data taken together, one write at a time
  assign misc_awready = misc_awvalid & misc_wvalid & ~misc_bvalid;
  assign misc_wready  = misc_awready;
  assign wr_fire      = misc_awready;
  assign misc_arready = misc_arvalid & ~misc_rvalid;
  assign rd_fire      = misc_arready;

  // window never errors
  assign misc_bresp = n310_mgmt_pkg::RESP_OKAY;
  assign misc_rresp = n310_mgmt_pkg::RESP_OKAY;

  ////////////////////
  // writes
  ////////////////////

  always_ff @(posedge FCLK_CLK0) begin
    if (FCLK_RESET0) begin
      misc_bvalid <= 1'b0;
      scratch     <= '0;
      led_gps     <= n310_mgmt_pkg::LED_GPS_RESET;
    end else begin
      if (wr_fire) begin
        misc_bvalid <= 1'b1;
      end else if (misc_bready) begin
        misc_bvalid <= 1'b0;
      end
      // ID and status offsets are read only, writes drop
      if (wr_fire && misc_awaddr[3:2] == n310_mgmt_pkg::MISC_OFF_SCRATCH[3:2]) begin
        for (int i = 0; i < n310_mgmt_pkg::REG_SW; i++) begin
          if (misc_wstrb[i]) begin
            scratch[8*i +: 8] <= misc_wdata[8*i +: 8];
          end
        end
      end
      // led lands on the same edge that raises bvalid
      if (wr_fire && misc_awaddr[3:2] == n310_mgmt_pkg::MISC_OFF_LED_CTRL[3:2] &&
          misc_wstrb[0]) begin
        led_gps <= misc_wdata[0];
      end
    end
  end

  ////////////////////
  // reads
  ////////////////////

  always_ff @(posedge FCLK_CLK0) begin
    if (FCLK_RESET0) begin
      misc_rvalid <= 1'b0;
    end else if (rd_fire) begin
      misc_rvalid <= 1'b1;
    end else if (misc_rready) begin
      misc_rvalid <= 1'b0;
    end
  end

  // read data captured at the address handshake, held until taken
  always_ff @(posedge FCLK_CLK0) begin
    if (rd_fire) begin
      case (misc_araddr[3:2])
        n310_mgmt_pkg::MISC_OFF_SCRATCH[3:2]: misc_rdata <= scratch;
        n310_mgmt_pkg::MISC_OFF_ID[3:2]:      misc_rdata <= n310_mgmt_pkg::MISC_ID;
        // sfp1 high half, sfp0 low half
        n310_mgmt_pkg::MISC_OFF_SFP_STATUS[3:2]: misc_rdata <= {sfp1_phy_status, sfp0_phy_status};
        default: misc_rdata <= {{(n310_mgmt_pkg::REG_DWIDTH-1){1'b0}}, led_gps};
      endcase
    end
  end

  // read response held under back-pressure
  assert property (@(posedge FCLK_CLK0) disable iff (FCLK_RESET0)
    misc_rvalid && !misc_rready |=> misc_rvalid && $stable(misc_rdata));

endmodule

`default_nettype wire

// File: rtl/n310_mgmt.sv
////////////////////
// n310 management top level
// register decode, misc window, heartbeat and SFP LEDs
////////////////////
`default_nettype none

module n310_mgmt #(
  parameter int HB_BIT = n310_mgmt_pkg::HEARTBEAT_BIT
) (
  input  wire                                     FCLK_CLK0,
  input  wire                                     FCLK_RESET0,
  input  wire  [n310_mgmt_pkg::BUS_AW-1:0]        axi_awaddr,
  input  wire                                     axi_awvalid,
  output logic                                    axi_awready,
  input  wire  [n310_mgmt_pkg::REG_DWIDTH-1:0]    axi_wdata,
  input  wire  [n310_mgmt_pkg::REG_SW-1:0]        axi_wstrb,
  input  wire                                     axi_wvalid,
  output logic                                    axi_wready,
  output logic [n310_mgmt_pkg::RESP_W-1:0]        axi_bresp,
  output logic                                    axi_bvalid,
  input  wire                                     axi_bready,
  input  wire  [n310_mgmt_pkg::BUS_AW-1:0]        axi_araddr,
  input  wire                                     axi_arvalid,
  output logic                                    axi_arready,
  output logic [n310_mgmt_pkg::REG_DWIDTH-1:0]    axi_rdata,
  output logic [n310_mgmt_pkg::RESP_W-1:0]        axi_rresp,
  output logic                                    axi_rvalid,
  input  wire                                     axi_rready,
  input  wire  [n310_mgmt_pkg::PHY_STATUS_W-1:0]  sfp0_phy_status,
  input  wire  [n310_mgmt_pkg::PHY_STATUS_W-1:0]  sfp1_phy_status,
  output logic                                    panel_led_link,
  output logic                                    panel_led_gps,
  output logic                                    sfp_0_led_b,
  output logic                                    sfp_1_led_b
);

  // misc window channels
  logic [n310_mgmt_pkg::REG_AWIDTH-1:0]  misc_awaddr, misc_araddr;
  logic [n310_mgmt_pkg::REG_DWIDTH-1:0]  misc_wdata, misc_rdata;
  logic [n310_mgmt_pkg::REG_SW-1:0]      misc_wstrb;
  logic [n310_mgmt_pkg::RESP_W-1:0]      misc_bresp, misc_rresp;
  logic misc_awvalid, misc_awready, misc_wvalid, misc_wready;
  logic misc_bvalid, misc_bready, misc_arvalid, misc_arready;
  logic misc_rvalid, misc_rready;
  // error responder channels
  logic [n310_mgmt_pkg::REG_DWIDTH-1:0]  dmy_rdata;
  logic [n310_mgmt_pkg::RESP_W-1:0]      dmy_bresp, dmy_rresp;
  logic dmy_awvalid, dmy_awready, dmy_wvalid, dmy_wready;
  logic dmy_bvalid, dmy_bready, dmy_arvalid, dmy_arready;
  logic dmy_rvalid, dmy_rready;

  axil_addr_decoder i_decoder (.*);

  misc_regs i_misc_regs (
    .*,
    .led_gps (panel_led_gps)
  );

  // everything outside the window errors out
  axil_dummy_slave #(.DEC_ERR(1'b1)) i_dummy (.*);

  heartbeat_led #(.HB_BIT(HB_BIT)) i_heartbeat (
    .FCLK_CLK0   (FCLK_CLK0),
    .FCLK_RESET0 (FCLK_RESET0),
    .led         (panel_led_link)
  );

  // SFP "B" LEDs follow PHY link up
  assign sfp_0_led_b = sfp0_phy_status[n310_mgmt_pkg::LINK_UP_BIT];
  assign sfp_1_led_b = sfp1_phy_status[n310_mgmt_pkg::LINK_UP_BIT];

endmodule

`default_nettype wire

// File: rtl/n310_mgmt_pkg.sv
////////////////////
// n310 management bus definitions
// widths, misc window map, response codes and LED constants
////////////////////
`default_nettype none

package n310_mgmt_pkg;

  // register bus widths
  localparam int BUS_AW     = 32;
  localparam int REG_AWIDTH = 14;
  localparam int REG_DWIDTH = 32;
  localparam int REG_SW     = REG_DWIDTH / 8;
  localparam int RESP_W     = 2;

  ////////////////////
  // address map
  ////////////////////

  // only the bits above REG_AWIDTH take part in the window compare
  localparam logic [BUS_AW-1:0] REG_BASE_MISC = 32'h4001_0000;

  // misc window offsets, decoded on bits [3:2]
  localparam logic [REG_AWIDTH-1:0] MISC_OFF_SCRATCH    = 14'h0;
  localparam logic [REG_AWIDTH-1:0] MISC_OFF_ID         = 14'h4;
  localparam logic [REG_AWIDTH-1:0] MISC_OFF_SFP_STATUS = 14'h8;
  localparam logic [REG_AWIDTH-1:0] MISC_OFF_LED_CTRL   = 14'hC;

  // read-only ID word
  localparam logic [REG_DWIDTH-1:0] MISC_ID = 32'h4E31_0001;

  // response codes
  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'd0;
  localparam logic [RESP_W-1:0] RESP_DECERR = 2'd3;

  ////////////////////
  // LEDs
  ////////////////////

  localparam int PHY_STATUS_W = 16;
  // status bit shown on the SFP "B" LED
  localparam int LINK_UP_BIT  = 0;
  // roughly a 1 s blink period at the bus clock
  localparam int HEARTBEAT_BIT = 26;
  localparam logic LED_GPS_RESET = 1'b1;

endpackage

`default_nettype wire

// File: verif/n310_mgmt_tb.sv
////////////////////
// n310 management testbench
// random register traffic checked against a register model
////////////////////
`default_nettype none

module n310_mgmt_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // about 300 accesses, at most 30 cycles each
  localparam int TIMEOUT_CYCLES = 10000;
  localparam int NUM_ITER       = 150;
  localparam logic [31:0] MISC_BASE = n310_mgmt_pkg::REG_BASE_MISC;

  logic        FCLK_CLK0   = 1'b0;
  logic        FCLK_RESET0 = 1'b1;
  logic [31:0] axi_awaddr, axi_wdata, axi_araddr, axi_rdata;
  logic [3:0]  axi_wstrb;
  logic [1:0]  axi_bresp, axi_rresp;
  logic        axi_awvalid, axi_awready, axi_wvalid, axi_wready, axi_bvalid;
  logic        axi_arvalid, axi_arready, axi_rvalid;
  logic        axi_bready = 1'b0;
  logic        axi_rready = 1'b0;
  logic [15:0] sfp0_phy_status, sfp1_phy_status;
  logic        panel_led_link, panel_led_gps, sfp_0_led_b, sfp_1_led_b;
  integer      seed   = 61;
  int          cycles = 0;
  // register model
  logic [31:0] scratch_m = '0;
  logic        led_m     = n310_mgmt_pkg::LED_GPS_RESET;
  // back-pressure and heartbeat monitor state
  logic        hold_b   = 1'b0;
  logic        hold_r   = 1'b0;
  logic        rst_prev = 1'b1;
  logic [1:0]  held_bresp, held_rresp;
  logic [31:0] held_rdata;
  int          hb_cnt = 0;

  n310_mgmt #(.HB_BIT(4)) i_dut (.*);

  always #20 FCLK_CLK0 = ~FCLK_CLK0;

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      $display("sim failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  ////////////////////
  // bus master
  ////////////////////

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp, output logic led_b);
    @(posedge FCLK_CLK0);
    axi_awaddr  <= addr;
    axi_wdata   <= data;
    axi_wstrb   <= strb;
    axi_awvalid <= 1'b1;
    axi_wvalid  <= 1'b1;
    do @(negedge FCLK_CLK0); while (!(axi_awready && axi_wready));
    @(posedge FCLK_CLK0);
    axi_awvalid <= 1'b0;
    axi_wvalid  <= 1'b0;
    // response due one cycle after the handshake
    @(negedge FCLK_CLK0);
    check_equal(axi_bvalid, 1'b1, "bvalid one cycle after write");
    led_b = panel_led_gps;
    while (!axi_bready) @(negedge FCLK_CLK0);
    resp = axi_bresp;
  endtask

  task automatic read_reg(input logic [31:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(posedge FCLK_CLK0);
    axi_araddr  <= addr;
    axi_arvalid <= 1'b1;
    do @(negedge FCLK_CLK0); while (!axi_arready);
    @(posedge FCLK_CLK0);
    axi_arvalid <= 1'b0;
    @(negedge FCLK_CLK0);
    check_equal(axi_rvalid, 1'b1, "rvalid one cycle after read");
    while (!axi_rready) @(negedge FCLK_CLK0);
    data = axi_rdata;
    resp = axi_rresp;
  endtask

  // random back-pressure, low about 30% of cycles
  always @(posedge FCLK_CLK0) begin
    axi_bready <= ({$random(seed)} % 10) >= 3;
    axi_rready <= ({$random(seed)} % 10) >= 3;
  end

  ////////////////////
  // monitors
  ////////////////////

  always @(negedge FCLK_CLK0) begin
    // held response must not move
    if (hold_b) begin
      check_equal(axi_bvalid, 1'b1, "bvalid dropped before bready");
      check_equal(axi_bresp, held_bresp, "bresp moved before bready");
    end
    if (hold_r) begin
      check_equal(axi_rvalid, 1'b1, "rvalid dropped before rready");
      check_equal(axi_rdata, held_rdata, "rdata moved before rready");
      check_equal(axi_rresp, held_rresp, "rresp moved before rready");
    end
    hold_b     = axi_bvalid && !axi_bready;
    hold_r     = axi_rvalid && !axi_rready;
    held_bresp = axi_bresp;
    held_rresp = axi_rresp;
    held_rdata = axi_rdata;
    // heartbeat: 16 cycles per level
    hb_cnt   = rst_prev ? 0 : hb_cnt + 1;
    rst_prev = FCLK_RESET0;
    check_equal(panel_led_link, hb_cnt[4], "heartbeat LED");
  end

  always @(posedge FCLK_CLK0) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish");
      $display("sim failed");
      $fatal(1, "cycle limit reached");
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    logic [31:0] addr, data, rdata;
    logic [15:0] s0, s1;
    logic [3:0]  strb;
    logic [1:0]  resp;
    logic        led_b, bit0;
    int          op;
    axi_awaddr      = '0;
    axi_wdata       = '0;
    axi_wstrb       = '0;
    axi_awvalid     = 1'b0;
    axi_wvalid      = 1'b0;
    axi_araddr      = '0;
    axi_arvalid     = 1'b0;
    sfp0_phy_status = '0;
    sfp1_phy_status = '0;
    repeat (2) @(posedge FCLK_CLK0);
    FCLK_RESET0 <= 1'b0;
    // quiet bus straight after reset
    @(negedge FCLK_CLK0);
    check_equal(axi_awready, 1'b0, "awready after reset");
    check_equal(axi_wready, 1'b0, "wready after reset");
    check_equal(axi_arready, 1'b0, "arready after reset");
    check_equal(axi_bvalid, 1'b0, "bvalid after reset");
    check_equal(axi_rvalid, 1'b0, "rvalid after reset");
    check_equal(panel_led_link, 1'b0, "link LED after reset");
    check_equal(panel_led_gps, 1'b1, "gps LED after reset");

    for (int i = 0; i < NUM_ITER; i++) begin
      op = {$random(seed)} % 6;
      // undecoded offset bits are random
      addr = MISC_BASE | ({$random(seed)} & 32'h0000_3FF3);
      case (op)
        0: begin
          data = $random(seed);
          strb = $random(seed);
          write_reg(addr, data, strb, resp, led_b);
          check_equal(resp, n310_mgmt_pkg::RESP_OKAY, "scratch write resp");
          for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
              scratch_m[8*b +: 8] = data[8*b +: 8];
            end
          end
        end
        1: begin
          read_reg(addr | 32'h0, rdata, resp);
          check_equal(rdata, scratch_m, "scratch read");
          check_equal(resp, n310_mgmt_pkg::RESP_OKAY, "scratch read resp");
        end
        2: begin
          // read-only targets ignore writes
          addr = addr | (($random(seed) & 1) ? 32'h4 : 32'h8);
          write_reg(addr, $random(seed), $random(seed), resp, led_b);
          check_equal(resp, n310_mgmt_pkg::RESP_OKAY, "read-only write resp");
          read_reg(addr, rdata, resp);
          check_equal(rdata, addr[3] ? {sfp1_phy_status, sfp0_phy_status} : n310_mgmt_pkg::MISC_ID,
                      "read-only register after write");
        end
        3: begin
          s0 = $random(seed);
          s1 = $random(seed);
          @(posedge FCLK_CLK0);
          sfp0_phy_status <= s0;
          sfp1_phy_status <= s1;
          @(negedge FCLK_CLK0);
          check_equal(sfp_0_led_b, s0[0], "sfp0 B LED");
          check_equal(sfp_1_led_b, s1[0], "sfp1 B LED");
          read_reg(addr | 32'h8, rdata, resp);
          check_equal(rdata, {s1, s0}, "sfp status read");
        end
        4: begin
          addr = $random(seed);
          if (addr[31:14] == MISC_BASE[31:14]) begin
            addr[31] = ~addr[31];
          end
          write_reg(addr, $random(seed), $random(seed), resp, led_b);
          check_equal(resp, n310_mgmt_pkg::RESP_DECERR, "unmapped write resp");
          read_reg(addr, rdata, resp);
          check_equal(resp, n310_mgmt_pkg::RESP_DECERR, "unmapped read resp");
          check_equal(rdata, 32'h0, "unmapped read data");
          read_reg(MISC_BASE, rdata, resp);
          check_equal(rdata, scratch_m, "scratch after unmapped access");
        end
        default: begin
          bit0 = $random(seed);
          // random upper bits, only bit 0 is kept
          data    = $random(seed);
          data[0] = bit0;
          write_reg(addr | 32'hC, data, 4'hF, resp, led_b);
          check_equal(led_b, bit0, "gps LED at bvalid");
          led_m = bit0;
          read_reg(addr | 32'hC, rdata, resp);
          check_equal(rdata, {31'h0, led_m}, "LED control read");
        end
      endcase
    end
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire
